/* logic/procPkg.sv */
// Shared ISA encodings and pipeline-register types for the 16-bit five-stage processor
package procPkg;

  // Opcode field, bits 15 to 12
  typedef enum logic [3:0] {
    opNop  = 4'd0,
    opAdd  = 4'd1,
    opSub  = 4'd2,
    opAnd  = 4'd3,
    opXor  = 4'd4,
    opAddi = 4'd5,
    opLd   = 4'd6,
    opSt   = 4'd7,
    opHalt = 4'd15
  } opcodeE;

  // ALU function, ordered to match opcode minus one for R-format
  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluAnd = 2'd2,
    aluXor = 2'd3
  } aluOpE;

  typedef logic [15:0] wordT;
  typedef logic [2:0]  regIdxT;

  // Three-register form
  typedef struct packed {
    opcodeE      opcode;
    regIdxT      rd;
    regIdxT      rs;
    regIdxT      rt;
    logic [2:0]  unused;
  } rFmtS;

  // Register plus 6-bit signed immediate
  typedef struct packed {
    opcodeE      opcode;
    regIdxT      rd;
    regIdxT      rs;
    logic [5:0]  imm6;
  } iFmtS;

  // Same instruction word, two views
  typedef union packed {
    rFmtS rFmt;
    iFmtS iFmt;
  } instrU;

  typedef struct packed {
    logic  valid;
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  useImm;
    logic  halt;
    aluOpE aluOp;
  } ctrlS;

  typedef struct packed {
    logic  valid;
    instrU instr;
  } ifIdS;

  typedef struct packed {
    ctrlS   ctrl;
    regIdxT dst;
    wordT   opA;
    wordT   opB;
    wordT   imm;
  } idExS;

  typedef struct packed {
    ctrlS   ctrl;
    regIdxT dst;
    wordT   aluRes;
    wordT   stData;
  } exMemS;

  typedef struct packed {
    logic   valid;
    logic   regWrite;
    logic   halt;
    regIdxT dst;
    wordT   data;
  } wbS;

  // Source registers of the instruction sitting in decode
  typedef struct packed {
    regIdxT srcA;
    regIdxT srcB;
    logic   useA;
    logic   useB;
  } srcUseS;

endpackage

/* logic/fetchStage.sv */
// Fetch stage with program counter, loadable instruction memory and IF/ID register
`timescale 1ns/1ps

module fetchStage import procPkg::*; #(
  parameter int imemAddrBits = 8
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    run,
  input  logic                    stall,
  input  logic                    haltSeen,
  input  logic                    imemWe,
  input  logic [imemAddrBits-1:0] imemAddr,
  input  wordT                    imemData,
  output ifIdS                    ifId
);

  localparam int imemDepth = 1 << imemAddrBits;

  wordT                    imem [imemDepth];
  logic [imemAddrBits-1:0] pc;
  logic                    validQ;
  wordT                    instrQ;
  logic                    advance;

  // Move on only while running, not stalled and no HALT decoded
  assign advance = run && !stall && !haltSeen;

  // Loader port, used while run is low
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc     <= '0;
      validQ <= 1'b0;
    end else if (!stall) begin
      // Bubble when idle or halted
      validQ <= advance;
      if (advance) begin
        pc <= pc + 1'b1;
      end
    end
  end

  // Instruction word, held with the valid bit on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      instrQ <= imem[pc];
    end
  end

  assign ifId = '{valid: validQ, instr: instrQ};

endmodule

/* logic/decodeStage.sv */
// Decode stage with control decode, register file, sticky error and ID/EX register
`timescale 1ns/1ps

module decodeStage import procPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  ifIdS   ifId,
  input  logic   stall,
  input  wbS     wb,
  output idExS   idEx,
  output srcUseS srcUse,
  output logic   haltSeen,
  output logic   err
);

  wordT   regs [8];
  instrU  instr;
  opcodeE op;
  ctrlS   ctrl;
  srcUseS src;
  logic   illegal;
  logic   wbWrite;
  wordT   opA;
  wordT   opB;
  wordT   imm;
  logic   haltQ;
  logic   errQ;
  ctrlS   ctrlQ;
  regIdxT dstQ;
  wordT   opAQ;
  wordT   opBQ;
  wordT   immQ;

  assign instr = ifId.instr;
  assign op    = instr.rFmt.opcode;
  assign imm   = {{10{instr.iFmt.imm6[5]}}, instr.iFmt.imm6};

  always_comb begin
    ctrl       = '0;
    src        = '0;
    illegal    = 1'b0;
    src.srcA   = instr.rFmt.rs;
    src.srcB   = instr.rFmt.rt;
    if (ifId.valid) begin
      ctrl.valid = 1'b1;
      case (op)
        opNop: ;
        opAdd, opSub, opAnd, opXor: begin
          ctrl.regWrite = 1'b1;
          // ADD..XOR are opcodes 1..4, ALU codes 0..3
          ctrl.aluOp    = aluOpE'(op[1:0] - 2'd1);
          src.useA      = 1'b1;
          src.useB      = 1'b1;
        end
        opAddi: begin
          ctrl.regWrite = 1'b1;
          ctrl.useImm   = 1'b1;
          src.useA      = 1'b1;
        end
        opLd: begin
          ctrl.regWrite = 1'b1;
          ctrl.memRead  = 1'b1;
          ctrl.useImm   = 1'b1;
          src.useA      = 1'b1;
        end
        opSt: begin
          ctrl.memWrite = 1'b1;
          ctrl.useImm   = 1'b1;
          // Store data comes from the rd field
          src.srcB      = instr.iFmt.rd;
          src.useA      = 1'b1;
          src.useB      = 1'b1;
        end
        opHalt: ctrl.halt = 1'b1;
        default: begin
          // Illegal opcode turns into a bubble
          ctrl.valid = 1'b0;
          illegal    = 1'b1;
        end
      endcase
    end
  end

  assign srcUse = src;

  // Register file, same-cycle write visible to the read
  assign wbWrite = wb.valid && wb.regWrite;
  assign opA = (wbWrite && wb.dst == src.srcA) ? wb.data : regs[src.srcA];
  assign opB = (wbWrite && wb.dst == src.srcB) ? wb.data : regs[src.srcB];

  always_ff @(posedge clk) begin
    if (wbWrite) begin
      regs[wb.dst] <= wb.data;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltQ <= 1'b0;
      errQ  <= 1'b0;
      ctrlQ <= '0;
    end else begin
      errQ <= errQ | illegal;
      if (ctrl.halt && !stall) begin
        haltQ <= 1'b1;
      end
      // Bubble into ID/EX while waiting on a producer
      ctrlQ <= stall ? '0 : ctrl;
    end
  end

  always_ff @(posedge clk) begin
    dstQ <= instr.rFmt.rd;
    opAQ <= opA;
    opBQ <= opB;
    immQ <= imm;
  end

  // Fetch stops in the same cycle HALT is decoded
  assign haltSeen = haltQ | ctrl.halt;
  assign err      = errQ;
  assign idEx     = '{ctrl: ctrlQ, dst: dstQ, opA: opAQ, opB: opBQ, imm: immQ};

endmodule

/* logic/hazardDetect.sv */
// RAW hazard check of the decode sources against writers in ID/EX and EX/MEM
`timescale 1ns/1ps

module hazardDetect import procPkg::*; (
  input  srcUseS srcUse,
  input  regIdxT idExDst,
  input  logic   idExRegWrite,
  input  regIdxT exMemDst,
  input  logic   exMemRegWrite,
  output logic   stall
);

  logic hitA;
  logic hitB;

  // regWrite is only set for valid entries, bubbles carry zero control
  // MEM/WB needs no check, the register file writes through
  assign hitA = srcUse.useA &&
                ((idExRegWrite && idExDst == srcUse.srcA) ||
                 (exMemRegWrite && exMemDst == srcUse.srcA));

  assign hitB = srcUse.useB &&
                ((idExRegWrite && idExDst == srcUse.srcB) ||
                 (exMemRegWrite && exMemDst == srcUse.srcB));

  // Register 0 is writable, no index excluded
  assign stall = hitA || hitB;

endmodule

/* logic/executeStage.sv */
// Execute stage with immediate select, ALU and EX/MEM register
`timescale 1ns/1ps

module executeStage import procPkg::*; (
  input  logic  clk,
  input  logic  arstN,
  input  idExS  idEx,
  output exMemS exMem
);

  wordT   opB;
  wordT   aluRes;
  ctrlS   ctrlQ;
  regIdxT dstQ;
  wordT   aluResQ;
  wordT   stDataQ;

  // ADDI, LD and ST take the immediate
  assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.opB;

  always_comb begin
    case (idEx.ctrl.aluOp)
      aluAdd:  aluRes = idEx.opA + opB;
      aluSub:  aluRes = idEx.opA - opB;
      aluAnd:  aluRes = idEx.opA & opB;
      default: aluRes = idEx.opA ^ opB;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlQ <= '0;
    end else begin
      ctrlQ <= idEx.ctrl;
    end
  end

  // Store data is the raw rd-field register, not the immediate
  always_ff @(posedge clk) begin
    dstQ    <= idEx.dst;
    aluResQ <= aluRes;
    stDataQ <= idEx.opB;
  end

  assign exMem = '{ctrl: ctrlQ, dst: dstQ, aluRes: aluResQ, stData: stDataQ};

endmodule

/* logic/memoryStage.sv */
// Memory stage with data memory, writeback select and MEM/WB register
`timescale 1ns/1ps

module memoryStage import procPkg::*; #(
  parameter int dmemAddrBits = 8
) (
  input  logic  clk,
  input  logic  arstN,
  input  exMemS exMem,
  output wbS    wb
);

  localparam int dmemDepth = 1 << dmemAddrBits;

  wordT                    dmem [dmemDepth];
  logic [dmemAddrBits-1:0] addr;
  wordT                    wbData;
  logic                    validQ;
  logic                    regWriteQ;
  logic                    haltQ;
  regIdxT                  dstQ;
  wordT                    dataQ;

  // Upper address bits ignored
  assign addr = exMem.aluRes[dmemAddrBits-1:0];

  always_ff @(posedge clk) begin
    if (exMem.ctrl.memWrite) begin
      dmem[addr] <= exMem.stData;
    end
  end

  // Asynchronous read, so a load right after a store sees it
  assign wbData = exMem.ctrl.memRead ? dmem[addr] : exMem.aluRes;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ    <= 1'b0;
      regWriteQ <= 1'b0;
      haltQ     <= 1'b0;
    end else begin
      validQ    <= exMem.ctrl.valid;
      regWriteQ <= exMem.ctrl.regWrite;
      // Sticky, stays set once HALT retires
      haltQ     <= haltQ | exMem.ctrl.halt;
    end
  end

  always_ff @(posedge clk) begin
    dstQ  <= exMem.dst;
    dataQ <= wbData;
  end

  assign wb = '{valid: validQ, regWrite: regWriteQ, halt: haltQ, dst: dstQ, data: dataQ};

endmodule

/* logic/proc.sv */
// Five-stage 16-bit in-order processor top joining the pipeline stages
`timescale 1ns/1ps

module proc import procPkg::*; #(
  parameter int imemAddrBits = 8,
  parameter int dmemAddrBits = 8
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    run,
  input  logic                    imemWe,
  input  logic [imemAddrBits-1:0] imemAddr,
  input  wordT                    imemData,
  output logic                    wbValid,
  output regIdxT                  wbReg,
  output wordT                    wbData,
  output logic                    halted,
  output logic                    err
);

  ifIdS   ifId;
  idExS   idEx;
  exMemS  exMem;
  wbS     wb;
  srcUseS srcUse;
  logic   stall;
  logic   haltSeen;

  fetchStage #(.imemAddrBits(imemAddrBits)) u_fetch (
    .clk      (clk),
    .arstN    (arstN),
    .run      (run),
    .stall    (stall),
    .haltSeen (haltSeen),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .ifId     (ifId)
  );

  decodeStage u_decode (
    .clk      (clk),
    .arstN    (arstN),
    .ifId     (ifId),
    .stall    (stall),
    .wb       (wb),
    .idEx     (idEx),
    .srcUse   (srcUse),
    .haltSeen (haltSeen),
    .err      (err)
  );

  // Stalls IF and ID until the producer leaves EX/MEM
  hazardDetect u_hazard (
    .srcUse        (srcUse),
    .idExDst       (idEx.dst),
    .idExRegWrite  (idEx.ctrl.regWrite),
    .exMemDst      (exMem.dst),
    .exMemRegWrite (exMem.ctrl.regWrite),
    .stall         (stall)
  );

  executeStage u_execute (
    .clk   (clk),
    .arstN (arstN),
    .idEx  (idEx),
    .exMem (exMem)
  );

  memoryStage #(.dmemAddrBits(dmemAddrBits)) u_memory (
    .clk   (clk),
    .arstN (arstN),
    .exMem (exMem),
    .wb    (wb)
  );

  // Observation port shows register writebacks only
  assign wbValid = wb.valid & wb.regWrite;
  assign wbReg   = wb.dst;
  assign wbData  = wb.data;
  assign halted  = wb.halt;

endmodule

/* tb/proc_props.sv */
// Pipeline invariant checks bound into the fetch and decode stages
`timescale 1ns/1ps

module procProps #(
  parameter int pcBits  = 8,
  parameter bit watchPc = 1'b0
) (
  input logic              clk,
  input logic              arstN,
  input logic              stall,
  input logic [pcBits-1:0] pc,
  input logic              err,
  input logic              idExValid
);

  if (watchPc) begin : pcChecks
    // PC frozen across a stall edge
    assert property (@(posedge clk) disable iff (!arstN) stall |=> $stable(pc))
      else $error("PC changed while stall was high");
  end else begin : decodeChecks
    // Sticky error flag
    assert property (@(posedge clk) disable iff (!arstN) err |=> err)
      else $error("err fell after being raised");

    // Every stall cycle leaves a bubble in ID/EX
    assert property (@(posedge clk) disable iff (!arstN) stall |=> !idExValid)
      else $error("valid entry loaded into ID/EX during a stall");
  end

endmodule

// Fetch side only watches the PC
bind fetchStage procProps #(.pcBits(imemAddrBits), .watchPc(1'b1)) u_fetchProps (
  .clk       (clk),
  .arstN     (arstN),
  .stall     (stall),
  .pc        (pc),
  .err       (1'b0),
  .idExValid (1'b0)
);

// Decode side watches the error flag and the ID/EX bubble
bind decodeStage procProps #(.pcBits(1), .watchPc(1'b0)) u_decodeProps (
  .clk       (clk),
  .arstN     (arstN),
  .stall     (stall),
  .pc        (1'b0),
  .err       (err),
  .idExValid (ctrlQ.valid)
);

/* tb/procTb.sv */
// Directed testbench for the five-stage processor against an in-order ISA model
`timescale 1ns/1ps

module procTb import procPkg::*; ();

  // Six tests of up to about 400 cycles each plus margin
  localparam int timeoutCycles = 3000;

  typedef struct packed {
    regIdxT dst;
    wordT   data;
  } wbRecS;

  logic        clk;
  logic        arstN;
  logic        run;
  logic        imemWe;
  logic [7:0]  imemAddr;
  wordT        imemData;
  logic        wbValid;
  regIdxT      wbReg;
  wordT        wbData;
  logic        halted;
  logic        err;

  wordT        prog [$];
  wbRecS       expWb [$];
  wbRecS       gotWb [$];
  int          errors;
  int          cycles = 0;
  logic [31:0] lcgState = 32'h6386;

  proc u_proc (
    .clk      (clk),
    .arstN    (arstN),
    .run      (run),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .wbValid  (wbValid),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .halted   (halted),
    .err      (err)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeoutCycles) begin
      $display("Timeout: the run reached %0d cycles before all tests finished", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // LCG step with the immediate taken from the middle bits
  function automatic logic [5:0] randImm();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[21:16];
  endfunction

  function automatic wordT encodeR(input logic [3:0] op, input regIdxT rd, rs, rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  function automatic wordT encodeI(input logic [3:0] op, input regIdxT rd, rs,
                                   input logic [5:0] imm);
    return {op, rd, rs, imm};
  endfunction

  task automatic reportError(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic resetDut();
    arstN  = 1'b0;
    run    = 1'b0;
    imemWe = 1'b0;
    repeat (8) begin
      @(posedge clk);
      #1;
    end
    arstN = 1'b1;
  endtask

  // Loader port writes one word per cycle while run is low
  task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) begin
      imemWe   = 1'b1;
      imemAddr = 8'(i);
      imemData = prog[i];
      @(posedge clk);
      #1;
    end
    imemWe = 1'b0;
  endtask

  // In-order interpretation of the ISA up to HALT
  task automatic modelProgram();
    wordT       mRegs [8];
    wordT       mMem [256];
    wordT       w;
    wordT       a;
    wordT       b;
    wordT       imm;
    wordT       res;
    regIdxT     rd;
    logic [7:0] addr;
    bit         writes;
    bit         stop;
    int         idx;
    expWb.delete();
    for (int i = 0; i < 256; i++) begin
      mMem[i] = '0;
      if (i < 8) begin
        mRegs[i] = '0;
      end
    end
    idx  = 0;
    stop = 1'b0;
    while (!stop && idx < prog.size()) begin
      w      = prog[idx];
      rd     = w[11:9];
      a      = mRegs[w[8:6]];
      b      = mRegs[w[5:3]];
      imm    = {{10{w[5]}}, w[5:0]};
      addr   = 8'(a + imm);
      res    = '0;
      writes = 1'b1;
      case (w[15:12])
        4'd1: res = a + b;
        4'd2: res = a - b;
        4'd3: res = a & b;
        4'd4: res = a ^ b;
        4'd5: res = a + imm;
        4'd6: res = mMem[addr];
        4'd7: begin
          mMem[addr] = mRegs[rd];
          writes     = 1'b0;
        end
        4'd15: begin
          stop   = 1'b1;
          writes = 1'b0;
        end
        // NOP and illegal opcodes retire silently
        default: writes = 1'b0;
      endcase
      if (writes) begin
        mRegs[rd] = res;
        expWb.push_back(wbRecS'{dst: rd, data: res});
      end
      idx++;
    end
  endtask

  task automatic sampleCycle(inout bit errSeen);
    if (wbValid) begin
      gotWb.push_back(wbRecS'{dst: wbReg, data: wbData});
    end
    if (errSeen && !err) begin
      reportError("err fell after being raised");
    end
    errSeen = errSeen | err;
  endtask

  task automatic compareWritebacks();
    if (gotWb.size() != expWb.size()) begin
      reportError($sformatf("%0d writebacks seen, %0d expected", gotWb.size(), expWb.size()));
    end
    for (int i = 0; i < gotWb.size() && i < expWb.size(); i++) begin
      if (gotWb[i] !== expWb[i]) begin
        reportError($sformatf("writeback %0d is r%0d=%h, expected r%0d=%h", i,
                              gotWb[i].dst, gotWb[i].data, expWb[i].dst, expWb[i].data));
      end
    end
  endtask

  // Run one program to HALT and watch 50 more cycles
  task automatic runProgram(input logic expectErr);
    bit errSeen;
    errSeen = 1'b0;
    gotWb.delete();
    modelProgram();
    resetDut();
    loadProgram();
    run = 1'b1;
    do begin
      @(posedge clk);
      #1;
      sampleCycle(errSeen);
    end while (!halted);
    repeat (50) begin
      @(posedge clk);
      #1;
      sampleCycle(errSeen);
      if (!halted) begin
        reportError("halted dropped after HALT retired");
      end
    end
    run = 1'b0;
    if (err !== expectErr) begin
      reportError($sformatf("err is %b at end of program, expected %b", err, expectErr));
    end
    compareWritebacks();
  endtask

  // Called while halted and err are still high from the previous program
  task automatic checkResetState();
    resetDut();
    if (wbValid !== 1'b0 || halted !== 1'b0 || err !== 1'b0) begin
      reportError($sformatf("after reset wbValid=%b halted=%b err=%b", wbValid, halted, err));
    end
  endtask

  task automatic independentAluOps();
    prog.delete();
    // Clear every register before the random offsets
    for (int r = 0; r < 8; r++) begin
      prog.push_back(encodeR(opXor, 3'(r), 3'(r), 3'(r)));
    end
    for (int r = 0; r < 8; r++) begin
      prog.push_back(encodeI(opAddi, 3'(r), 3'(r), randImm()));
    end
    prog.push_back(encodeR(opAdd, 3'd0, 3'd1, 3'd2));
    prog.push_back(encodeR(opSub, 3'd1, 3'd3, 3'd4));
    prog.push_back(encodeR(opAnd, 3'd2, 3'd5, 3'd6));
    prog.push_back(encodeR(opXor, 3'd3, 3'd7, 3'd0));
    prog.push_back(encodeR(opHalt, 3'd0, 3'd0, 3'd0));
    prog.push_back(encodeI(opAddi, 3'd5, 3'd5, 6'd1));
    runProgram(1'b0);
  endtask

  task automatic dependentChain();
    prog.delete();
    prog.push_back(encodeR(opXor, 3'd1, 3'd1, 3'd1));
    prog.push_back(encodeI(opAddi, 3'd1, 3'd1, 6'd5));
    prog.push_back(encodeI(opAddi, 3'd2, 3'd1, 6'h3d));
    prog.push_back(encodeR(opAdd, 3'd3, 3'd2, 3'd1));
    prog.push_back(encodeI(opAddi, 3'd3, 3'd3, 6'd7));
    prog.push_back(encodeR(opAdd, 3'd4, 3'd3, 3'd3));
    prog.push_back(encodeR(opSub, 3'd5, 3'd4, 3'd2));
    prog.push_back(encodeI(opAddi, 3'd1, 3'd5, randImm()));
    prog.push_back(encodeR(opXor, 3'd6, 3'd1, 3'd5));
    prog.push_back(encodeR(opHalt, 3'd0, 3'd0, 3'd0));
    runProgram(1'b0);
  endtask

  task automatic storeThenLoad();
    prog.delete();
    prog.push_back(encodeR(opXor, 3'd0, 3'd0, 3'd0));
    prog.push_back(encodeI(opAddi, 3'd1, 3'd0, 6'd11));
    prog.push_back(encodeI(opAddi, 3'd2, 3'd0, 6'h39));
    prog.push_back(encodeI(opAddi, 3'd3, 3'd0, 6'd20));
    // ST data register sits in the rd field
    prog.push_back(encodeI(opSt, 3'd1, 3'd3, 6'd0));
    prog.push_back(encodeI(opSt, 3'd2, 3'd3, 6'd1));
    prog.push_back(encodeI(opSt, 3'd3, 3'd3, 6'h3e));
    prog.push_back(encodeI(opLd, 3'd4, 3'd3, 6'd0));
    prog.push_back(encodeI(opLd, 3'd5, 3'd3, 6'd1));
    prog.push_back(encodeI(opLd, 3'd6, 3'd3, 6'h3e));
    prog.push_back(encodeI(opAddi, 3'd7, 3'd0, 6'd25));
    // Load right behind its store
    prog.push_back(encodeI(opSt, 3'd7, 3'd0, 6'd5));
    prog.push_back(encodeI(opLd, 3'd1, 3'd0, 6'd5));
    prog.push_back(encodeR(opHalt, 3'd0, 3'd0, 3'd0));
    runProgram(1'b0);
  endtask

  task automatic illegalOpcode();
    prog.delete();
    prog.push_back(encodeR(opXor, 3'd2, 3'd2, 3'd2));
    prog.push_back(encodeI(opAddi, 3'd2, 3'd2, 6'd9));
    prog.push_back(encodeI(4'd8, 3'd3, 3'd2, 6'd1));
    prog.push_back(encodeI(opAddi, 3'd4, 3'd2, 6'h3f));
    prog.push_back(encodeR(opHalt, 3'd0, 3'd0, 3'd0));
    runProgram(1'b1);
  endtask

  task automatic haltStopsFetch();
    prog.delete();
    prog.push_back(encodeR(opXor, 3'd1, 3'd1, 3'd1));
    prog.push_back(encodeI(opAddi, 3'd1, 3'd1, 6'd3));
    prog.push_back(encodeR(opHalt, 3'd0, 3'd0, 3'd0));
    // Never fetched
    prog.push_back(encodeI(opAddi, 3'd2, 3'd1, 6'd1));
    prog.push_back(encodeI(opAddi, 3'd3, 3'd1, 6'd2));
    prog.push_back(encodeR(opAdd, 3'd4, 3'd1, 3'd1));
    runProgram(1'b0);
  endtask

  initial begin
    clk      = 1'b0;
    arstN    = 1'b0;
    run      = 1'b0;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    errors   = 0;
    independentAluOps();
    dependentChain();
    storeThenLoad();
    illegalOpcode();
    checkResetState();
    haltStopsFetch();
    $display("All tests run, %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* proc.f */
logic/procPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/hazardDetect.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/proc.sv
tb/proc_props.sv
tb/procTb.sv

/* Makefile */
TOP = procTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f proc.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
